//--- acqSequencer.sv
// Tracks the fixed sample order: samples, then pixels, then acquisitions
// Samples must arrive in order with no gaps inside the count
// wrEn must stay low for 4 cycles after the last sample of a pass
`timescale 1ns/100ps
`include "sifhDefines.svh"

module acqSequencer (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wrEn,
    output sifhCtrlPkg::passT  pass,
    output sifhDataPkg::pixelT pixel,
    output logic               passEnd,
    output logic               histClear
);
    import sifhDataPkg::*;
    import sifhCtrlPkg::*;

    localparam int SAMPLE_W = (`DATA_NUM > 1) ? $clog2(`DATA_NUM) : 1;
    localparam int ACQ_W    = (`ACQ_NUM > 1) ? $clog2(`ACQ_NUM) : 1;

    logic [SAMPLE_W-1:0] sampleCnt;   // Sample within pixel
    logic [ACQ_W-1:0]    acqCnt;      // Acquisition within pass
    logic                pixelDone;   // Last sample of this pixel
    logic                acqDone;     // Last sample of this acquisition
    logic                lastSample;  // Last sample of the pass
    logic                endD1;       // End event, one cycle late

    assign pixelDone  = (sampleCnt == SAMPLE_W'(`DATA_NUM - 1));
    assign acqDone    = pixelDone && (pixel == pixelT'(`PIXEL_NUM - 1));
    assign lastSample = wrEn && acqDone && (acqCnt == ACQ_W'(`ACQ_NUM - 1));

    // ****************************************
    // Position counters
    // ****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixel     <= '0;
            acqCnt    <= '0;
        end else if (wrEn) begin
            if (!pixelDone) begin
                sampleCnt <= sampleCnt + 1'b1;
            end else begin
                sampleCnt <= '0;
                if (!acqDone) begin
                    pixel <= pixel + 1'b1;   // Next pixel
                end else begin
                    pixel <= '0;
                    if (acqCnt == ACQ_W'(`ACQ_NUM - 1)) begin
                        acqCnt <= '0;        // Pass complete
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end
            end
        end
    end

    // Pass toggle and end-of-pass pipeline
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pass      <= COARSE;
            endD1     <= 1'b0;
            passEnd   <= 1'b0;
            histClear <= 1'b0;
        end else begin
            if (lastSample) begin
                pass <= (pass == COARSE) ? FINE : COARSE;
            end
            endD1     <= lastSample;
            passEnd   <= endD1;     // Peaks have settled by now
            histClear <= passEnd;   // After windowCalc has sampled the peaks
        end
    end

endmodule

//--- histogramBank.sv
// Register-array histograms, one per pixel, pixel-major addressing
// Valid bits give a single-cycle clear at the end of a pass
// Counts wrap if PEAK_MAX is too narrow for the pass length
// Output fields hold their last value while cntValid is low
`timescale 1ns/100ps
`include "sifhDefines.svh"

module histogramBank (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               wrEn,
    input  logic               binHit,
    input  sifhDataPkg::binT   bin,
    input  sifhDataPkg::pixelT pixel,
    input  logic               histClear,
    output logic               cntValid,
    output sifhDataPkg::pixelT cntPixel,
    output sifhDataPkg::binT   cntBin,
    output sifhDataPkg::countT cntValue
);
    import sifhDataPkg::*;

    localparam int ENTRY_NUM = `PIXEL_NUM * `BIN_NUM_PER_HIS;
    localparam int ADDR_W    = $bits(pixelT) + `NB;

    countT                binCount [ENTRY_NUM];  // Count storage
    logic [ENTRY_NUM-1:0] binValid;              // Entry written during this pass
    logic [ADDR_W-1:0]    addr;
    countT                nextCount;
    logic                 doInc;                 // Accepted sample

    assign addr  = {pixel, bin};   // pixel*BIN_NUM_PER_HIS + bin
    assign doInc = wrEn && binHit;

    // Stale entries restart at one
    assign nextCount = binValid[addr] ? binCount[addr] + 1'b1 : countT'(1);

    // ****************************************
    // Read-modify-write
    // ****************************************
    always_ff @(posedge clk) begin
        if (doInc) begin
            binCount[addr] <= nextCount;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (histClear) begin
            binValid <= '0;          // Whole bank empty in one cycle
        end else if (doInc) begin
            binValid[addr] <= 1'b1;
        end
    end

    // ****************************************
    // Registered count for the peak tracker
    // ****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            cntValid <= 1'b0;
        end else begin
            cntValid <= doInc;       // One cycle after the hit
        end
    end

    always_ff @(posedge clk) begin
        if (doInc) begin
            cntPixel <= pixel;
            cntBin   <= bin;
            cntValue <= nextCount;   // Same value just written back
        end
    end

endmodule

//--- peakTracker.sv
// Running per-pixel maximum over the counts from the histogram bank
// Strictly greater wins, so a tie keeps the bin that got there first
// Final peaks are stable the cycle after the last count arrives
`timescale 1ns/100ps
`include "sifhDefines.svh"

module peakTracker (
    input  logic                      clk,
    input  logic                      combin_res,
    input  logic                      histClear,
    input  logic                      cntValid,
    input  sifhDataPkg::pixelT        cntPixel,
    input  sifhDataPkg::binT          cntBin,
    input  sifhDataPkg::countT        cntValue,
    output logic [`PIXEL_NUM*`NB-1:0] peakBin
);
    import sifhDataPkg::*;

    countT runMax [`PIXEL_NUM];   // Highest count so far
    binT   runBin [`PIXEL_NUM];   // Bin that produced it

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                runMax[p] <= '0;
                runBin[p] <= '0;
            end
        end else if (histClear) begin
            // New pass starts from an empty maximum
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                runMax[p] <= '0;
                runBin[p] <= '0;
            end
        end else if (cntValid && (cntValue > runMax[cntPixel])) begin
            runMax[cntPixel] <= cntValue;
            runBin[cntPixel] <= cntBin;    // Only on a strict increase
        end
    end

    // Flatten, pixel 0 in the low bits
    for (genvar p = 0; p < `PIXEL_NUM; p++) begin : gPeak
        assign peakBin[p*`NB +: `NB] = runBin[p];
    end

endmodule

//--- sampleFilter.sv
// Combinational bin mapping for the current pass
// Fine-pass windows are only meaningful after a coarse pass has closed
// bin is don't-care whenever binHit is low
`timescale 1ns/100ps
`include "sifhDefines.svh"

module sampleFilter (
    input  sifhCtrlPkg::passT         pass,
    input  sifhDataPkg::pixelT        pixel,
    input  sifhDataPkg::sampleT       data,
    input  logic [`PIXEL_NUM*`NP-1:0] windowLow,
    output logic                      binHit,
    output sifhDataPkg::binT          bin
);
    import sifhDataPkg::*;
    import sifhCtrlPkg::*;

    sampleT lowEdge;    // Window of the pixel now being sampled
    sampleT highEdge;   // Inclusive top of the window
    sampleT offset;     // Sample relative to the low edge

    assign lowEdge  = windowLow[pixel*`NP +: `NP];
    assign highEdge = lowEdge + sampleT'(`BIN_NUM_PER_HIS - 1);  // Never wraps, low edge is clamped
    assign offset   = data - lowEdge;

    // Pass dependent mapping
    always_comb begin
        if (pass == COARSE) begin
            binHit = 1'b1;                 // Every sample counts
            bin    = data[`NP-1 -: `NB];   // Top NB bits
        end else begin
            // Drop anything outside the window
            binHit = (data >= lowEdge) && (data <= highEdge);
            bin    = offset[`NB-1:0];      // Upper bits are zero when inside
        end
    end

endmodule

//--- sifhCtrlPkg.sv
// Control types for the two-pass sequence
// COARSE is the state after reset

package sifhCtrlPkg;

    // Which histogram pass is running
    typedef enum logic {
        COARSE = 1'b0,  // Top NB bits of every sample
        FINE   = 1'b1   // Full resolution inside the window
    } passT;

endpackage

//--- sifhDataPkg.sv
// Datapath types shared by the histogram blocks
// All widths come from the defines header
`include "sifhDefines.svh"

package sifhDataPkg;

    // Pixel index width, never below one bit
    localparam int PIXEL_W = (`PIXEL_NUM > 1) ? $clog2(`PIXEL_NUM) : 1;

    typedef logic [`NP-1:0]       sampleT;  // Raw sample or final result
    typedef logic [`NB-1:0]       binT;     // Bin inside one histogram
    typedef logic [`PEAK_MAX-1:0] countT;   // Hits in one bin
    typedef logic [PIXEL_W-1:0]   pixelT;   // Pixel index

endpackage

//--- sifhDefines.svh
// Build-time sizes of the peak finder
// NB must stay below NP
// PEAK_MAX must be wide enough for DATA_NUM*ACQ_NUM hits in one bin
// Changing NP or NB changes both the coarse bins and the fine window
`ifndef SIFH_DEFINES_SVH
`define SIFH_DEFINES_SVH

// ****************************************
// Sample and bin geometry
// ****************************************
`define NP 8                  // Sample width
`define NB 4                  // Bin address width
`define BIN_NUM_PER_HIS (1 << `NB)   // Bins per pixel histogram

// ****************************************
// Acquisition shape
// ****************************************
`define DATA_NUM 4            // Samples per pixel per acquisition
`define PIXEL_NUM 2           // Pixels in the array
`define ACQ_NUM 3             // Acquisitions per pass

// Bin counter width
`define PEAK_MAX 8

`endif

//--- sifhHistogrammer.sv
// Two-pass histogram peak finder, top level
// One sample per cycle, no back-pressure
// result is valid only while resultValid pulses, pixel 0 in the low bits
`timescale 1ns/100ps
`include "sifhDefines.svh"

module sifhHistogrammer (
    input  logic                      clk,
    input  logic                      combin_res,
    input  logic                      wrEn,
    input  sifhDataPkg::sampleT       data,
    output logic [`PIXEL_NUM*`NP-1:0] result,
    output logic                      resultValid
);
    import sifhDataPkg::*;
    import sifhCtrlPkg::*;

    passT                      pass;        // Current pass
    pixelT                     pixel;       // Pixel of the incoming sample
    logic                      passEnd;
    logic                      histClear;
    logic                      binHit;      // Sample accepted by the filter
    binT                       bin;
    logic                      cntValid;    // Updated count available
    pixelT                     cntPixel;
    binT                       cntBin;
    countT                     cntValue;
    logic [`PIXEL_NUM*`NB-1:0] peakBin;
    logic [`PIXEL_NUM*`NP-1:0] windowLow;

    acqSequencer uSeq (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .pass       (pass),
        .pixel      (pixel),
        .passEnd    (passEnd),
        .histClear  (histClear)
    );

    sampleFilter uFilter (
        .pass      (pass),
        .pixel     (pixel),
        .data      (data),
        .windowLow (windowLow),
        .binHit    (binHit),
        .bin       (bin)
    );

    histogramBank uHist (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .binHit     (binHit),
        .bin        (bin),
        .pixel      (pixel),
        .histClear  (histClear),
        .cntValid   (cntValid),
        .cntPixel   (cntPixel),
        .cntBin     (cntBin),
        .cntValue   (cntValue)
    );

    peakTracker uPeak (
        .clk        (clk),
        .combin_res (combin_res),
        .histClear  (histClear),
        .cntValid   (cntValid),
        .cntPixel   (cntPixel),
        .cntBin     (cntBin),
        .cntValue   (cntValue),
        .peakBin    (peakBin)
    );

    windowCalc uCalc (
        .clk         (clk),
        .combin_res  (combin_res),
        .pass        (pass),
        .passEnd     (passEnd),
        .peakBin     (peakBin),
        .windowLow   (windowLow),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

//--- src.f
+incdir+.
sifhDataPkg.sv
sifhCtrlPkg.sv
sampleFilter.sv
histogramBank.sv
peakTracker.sv
windowCalc.sv
acqSequencer.sv
sifhHistogrammer.sv
tbSifh.sv

//--- tbSifh.sv
// Directed testbench for the two-pass histogram peak finder
// Stimulus is driven on the falling edge, outputs checked there as well
// Expected results come from a behavioural model of the window and peak rules
// Assumes the default sizes, PEAK_MAX must hold DATA_NUM*ACQ_NUM
`timescale 1ns/100ps
`include "sifhDefines.svh"

module tbSifh;
    import sifhDataPkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int PASS_LEN    = `DATA_NUM * `PIXEL_NUM * `ACQ_NUM;
    localparam int FRAME_NUM   = 8;                        // Frames over all tests
    localparam int TEST_CYCLES = 10 + 4 + FRAME_NUM * 2 * (PASS_LEN + 4);

    logic                      clk;
    logic                      combin_res;
    logic                      wrEn;
    sampleT                    data;
    logic [`PIXEL_NUM*`NP-1:0] result;
    logic                      resultValid;

    sampleT      coarseS [PASS_LEN];    // Samples of the coarse pass, arrival order
    sampleT      fineS   [PASS_LEN];    // Samples of the fine pass
    sampleT      expRes  [`PIXEL_NUM];  // Model output per pixel
    logic [31:0] lfsrState = 32'h6cec;
    bit          resultSeen = 1'b0;     // First frame finished

    sifhHistogrammer DUT (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .result      (result),
        .resultValid (resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Ends the run if the tests stall
    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        reportFail("watchdog timeout, the tests did not finish in time");
    end

    task automatic reportFail(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopping at the first error");
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic int idx(input int a, input int p, input int k);
        return (a * `PIXEL_NUM + p) * `DATA_NUM + k;   // Acquisition, pixel, sample
    endfunction

    // v1 on every everyN-th sample of the pixel, v0 elsewhere
    task automatic fillPixel(input bit isFine, input int pix, input sampleT v0,
                             input sampleT v1, input int everyN);
        int     j;
        sampleT v;
        j = 0;
        for (int a = 0; a < `ACQ_NUM; a++) begin
            for (int k = 0; k < `DATA_NUM; k++) begin
                v = ((j % everyN) == everyN - 1) ? v1 : v0;
                if (isFine) fineS[idx(a, pix, k)] = v;
                else coarseS[idx(a, pix, k)] = v;
                j++;
            end
        end
    endtask

    // ****************************************
    // Reference model
    // ****************************************
    task automatic computeExpected();
        int cnt [`BIN_NUM_PER_HIS];
        int best;
        int pk;
        int low;
        int s;
        int b;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            foreach (cnt[i]) cnt[i] = 0;
            best = 0;
            pk   = 0;
            for (int i = 0; i < `ACQ_NUM * `DATA_NUM; i++) begin
                s = coarseS[idx(i / `DATA_NUM, p, i % `DATA_NUM)];
                b = s >> (`NP - `NB);              // Top bits only
                cnt[b]++;
                if (cnt[b] > best) begin           // First to reach a count keeps it
                    best = cnt[b];
                    pk   = b;
                end
            end
            low = (pk << (`NP - `NB)) - `BIN_NUM_PER_HIS / 2;
            if (low < 0) low = 0;
            if (low > (1 << `NP) - `BIN_NUM_PER_HIS) low = (1 << `NP) - `BIN_NUM_PER_HIS;
            foreach (cnt[i]) cnt[i] = 0;
            best = 0;
            pk   = 0;
            for (int i = 0; i < `ACQ_NUM * `DATA_NUM; i++) begin
                s = fineS[idx(i / `DATA_NUM, p, i % `DATA_NUM)];
                if (s >= low && s <= low + `BIN_NUM_PER_HIS - 1) begin
                    b = s - low;
                    cnt[b]++;
                    if (cnt[b] > best) begin
                        best = cnt[b];
                        pk   = b;
                    end
                end
            end
            expRes[p] = sampleT'(low + pk);
        end
    endtask

    task automatic checkResults();
        sampleT got;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            got = result[p*`NP +: `NP];
            assert (got == expRes[p]) else reportFail($sformatf(
                "mismatch result[%0d]: got %h expected %h", p, got, expRes[p]));
        end
    endtask

    // ****************************************
    // Pass and frame drivers
    // ****************************************
    task automatic sendPass(input bit isFine);
        for (int i = 0; i < PASS_LEN; i++) begin
            assert (!resultValid) else reportFail("resultValid pulsed while samples arrived");
            if (!resultSeen) begin
                assert (result == '0) else reportFail($sformatf(
                    "mismatch result: got %h expected %h", result, '0));
            end
            wrEn = 1'b1;
            data = isFine ? fineS[i] : coarseS[i];
            @(negedge clk);
        end
        wrEn = 1'b0;
        data = '0;
        for (int c = 0; c < 4; c++) begin   // Now after edge c of the end timing
            if (isFine && c == 2) begin
                assert (resultValid) else
                    reportFail("resultValid did not arrive 3 cycles after the last sample");
                checkResults();
            end else begin
                assert (!resultValid) else reportFail("resultValid pulsed at the wrong cycle");
            end
            @(negedge clk);
        end
    endtask

    task automatic runFrame();
        computeExpected();
        sendPass(1'b0);
        sendPass(1'b1);
        resultSeen = 1'b1;
    endtask

    // ****************************************
    // Tests
    // ****************************************
    task automatic idleAfterReset();
        repeat (4) begin
            assert (!resultValid) else reportFail("resultValid high after reset");
            assert (result == '0) else reportFail($sformatf(
                "mismatch result: got %h expected %h", result, '0));
            @(negedge clk);
        end
    endtask

    task automatic clusterFrame();
        for (int f = 0; f < 2; f++) begin
            fillPixel(f, 0, 8'h35, 8'h36, 3);
            fillPixel(f, 1, 8'hA2, 8'hA0, 4);
        end
        runFrame();
    endtask

    task automatic clampFrame();
        for (int f = 0; f < 2; f++) begin
            fillPixel(f, 0, 8'h02, 8'h03, 3);   // Low edge clamps at 0
            fillPixel(f, 1, 8'hF5, 8'hFE, 3);   // 0xFE above the top window
        end
        runFrame();
    endtask

    task automatic windowFilterFrame(input sampleT inWin);
        fillPixel(0, 0, 8'h80, 8'h84, 2);       // Coarse peak in bin 8
        fillPixel(1, 0, 8'h20, inWin, 3);       // Mostly outside the window
        fillPixel(0, 1, 8'h50, 8'h51, 2);
        fillPixel(1, 1, 8'h50, 8'h51, 2);
        runFrame();
    endtask

    task automatic tieFrame();
        for (int f = 0; f < 2; f++) begin
            fillPixel(f, 0, 8'h47, 8'h42, 2);   // Equal counts, 0x47 leads
            fillPixel(f, 1, 8'h61, 8'h6E, 2);
        end
        runFrame();
    endtask

    task automatic randomFrame();
        sampleT base;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            base = sampleT'(randBits(`NP));
            for (int i = 0; i < PASS_LEN / `PIXEL_NUM; i++) begin
                coarseS[idx(i / `DATA_NUM, p, i % `DATA_NUM)] = base + sampleT'(randBits(2));
                fineS[idx(i / `DATA_NUM, p, i % `DATA_NUM)]   = base + sampleT'(randBits(2));
            end
        end
        runFrame();
    endtask

    initial begin
        combin_res = 1'b0;
        wrEn       = 1'b0;
        data       = '0;
        repeat (10) @(negedge clk);
        combin_res = 1'b1;
        idleAfterReset();
        clusterFrame();
        clampFrame();
        windowFilterFrame(8'h7A);
        windowFilterFrame(8'h85);   // In-window value moves the result
        tieFrame();
        repeat (3) randomFrame();   // Back to back, histograms must clear
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- windowCalc.sv
// Window and result arithmetic at the end of each pass
// pass has already toggled when passEnd arrives
// FINE here means the coarse pass just closed, and the reverse
// result holds its value until the next fine pass closes
`timescale 1ns/100ps
`include "sifhDefines.svh"

module windowCalc (
    input  logic                      clk,
    input  logic                      combin_res,
    input  sifhCtrlPkg::passT         pass,
    input  logic                      passEnd,
    input  logic [`PIXEL_NUM*`NB-1:0] peakBin,
    output logic [`PIXEL_NUM*`NP-1:0] windowLow,
    output logic [`PIXEL_NUM*`NP-1:0] result,
    output logic                      resultValid
);
    import sifhDataPkg::*;
    import sifhCtrlPkg::*;

    localparam sampleT HALF_WIN = sampleT'(`BIN_NUM_PER_HIS / 2);
    localparam sampleT MAX_LOW  = sampleT'((1 << `NP) - `BIN_NUM_PER_HIS);

    logic [`PIXEL_NUM*`NP-1:0] lowNext;   // Clamped edges from coarse peaks
    logic [`PIXEL_NUM*`NP-1:0] resNext;   // Fine peaks back in sample units

    // ****************************************
    // Per-pixel arithmetic
    // ****************************************
    for (genvar p = 0; p < `PIXEL_NUM; p++) begin : gPix
        sampleT centre;
        sampleT rawLow;

        // Coarse bin scaled back to a sample value
        assign centre = {peakBin[p*`NB +: `NB], {(`NP - `NB){1'b0}}};
        assign rawLow = (centre < HALF_WIN) ? '0 : centre - HALF_WIN;   // Clamp at 0
        assign lowNext[p*`NP +: `NP] = (rawLow > MAX_LOW) ? MAX_LOW : rawLow;
        assign resNext[p*`NP +: `NP] = sampleT'(peakBin[p*`NB +: `NB])
                                       + windowLow[p*`NP +: `NP];
    end

    // ****************************************
    // End-of-pass registers
    // ****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            windowLow   <= '0;
            result      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;              // Single-cycle pulse
            if (passEnd && (pass == FINE)) begin
                windowLow <= lowNext;         // Windows for the fine pass
            end
            if (passEnd && (pass == COARSE)) begin
                result      <= resNext;       // All pixels at once
                resultValid <= 1'b1;
            end
        end
    end

endmodule
